// ==== Makefile ====
# Verilator simulation of the execution unit testbench

VERILATOR ?= verilator
TOP       ?= tb_execution_unit
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= test passed
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== all.f ====
exu_pkg.sv
exu_issue_if.sv
uop_decoder.sv
integer_unit.sv
csr_unit.sv
result_writeback.sv
execution_unit.sv
execution_unit_sva.sv
tb_execution_unit.sv

// ==== csr_unit.sv ====
//====================
// CSR unit
// Status, scratch and retired counter with swap, set and
// clear accesses and the illegal access check
//====================

`timescale 1ns/100ps

module csr_unit (
    input  logic                clk_i,
    input  logic                rst_n_i,
    exu_issue_if.sink           issue,
    input  logic                retire_i,
    output logic                done_o,
    output exu_pkg::data_word_t data_o,
    output logic                exception_o,
    output logic                glb_interrupt_enable_o
);

    logic                csr_hit;
    logic                addr_known;
    logic                illegal;
    logic                write_en;
    exu_pkg::data_word_t old_value;
    exu_pkg::data_word_t new_value;

    exu_pkg::data_word_t status_q;
    exu_pkg::data_word_t scratch_q;
    exu_pkg::data_word_t instret_q;

    assign csr_hit = issue.valid && (issue.unit == exu_pkg::UNIT_CSR);

    // Read side, an address outside the map reads zero
    always_comb begin : csr_read
        addr_known = 1'b1;
        case (issue.csr_addr)
            exu_pkg::CSR_STATUS:  old_value = status_q;
            exu_pkg::CSR_SCRATCH: old_value = scratch_q;
            exu_pkg::CSR_INSTRET: old_value = instret_q;
            default: begin
                old_value  = '0;
                addr_known = 1'b0;
            end
        endcase
    end : csr_read

    // Write value
    always_comb begin : csr_modify
        case (issue.op)
            exu_pkg::OP_CSRRW: new_value = issue.operand_a;
            exu_pkg::OP_CSRRS: new_value = old_value | issue.operand_a;
            exu_pkg::OP_CSRRC: new_value = old_value & ~issue.operand_a;
            default:           new_value = old_value;
        endcase
    end : csr_modify

    // INSTRET is read only, so only a set or clear with a zero mask may touch it
    assign illegal = !addr_known ||
                     ((issue.csr_addr == exu_pkg::CSR_INSTRET) &&
                      ((issue.op == exu_pkg::OP_CSRRW) || (issue.operand_a != '0)));

    assign write_en = csr_hit && !illegal;

    always_ff @(posedge clk_i or negedge rst_n_i) begin : csr_regs
        if (!rst_n_i) begin
            status_q  <= '0;
            scratch_q <= '0;
            instret_q <= '0;
        end else begin
            if (write_en && (issue.csr_addr == exu_pkg::CSR_STATUS)) begin
                status_q <= new_value & exu_pkg::STATUS_WRITE_MASK;
            end
            if (write_en && (issue.csr_addr == exu_pkg::CSR_SCRATCH)) begin
                scratch_q <= new_value;
            end
            // Counts every op the result stage retires without exception
            if (retire_i) begin
                instret_q <= instret_q + 1'b1;
            end
        end
    end : csr_regs

    // Result, the old value on a legal access and zero otherwise
    always_ff @(posedge clk_i or negedge rst_n_i) begin : csr_result
        if (!rst_n_i) begin
            done_o      <= 1'b0;
            exception_o <= 1'b0;
            data_o      <= '0;
        end else begin
            done_o      <= csr_hit;
            exception_o <= csr_hit && illegal;
            data_o      <= write_en ? old_value : '0;
        end
    end : csr_result

    assign glb_interrupt_enable_o = status_q[exu_pkg::STATUS_GIE_BIT];

endmodule : csr_unit

// ==== execution_unit.sv ====
//====================
// Execution unit
// Decoder, integer unit, CSR unit and result stage behind a
// four phase req/ack handshake
//====================

`timescale 1ns/100ps

module execution_unit (
    input  logic                clk_i,
    input  logic                rst_n_i,

    // Host request
    input  logic                req_i,
    input  exu_pkg::exu_op_t    op_i,
    input  exu_pkg::data_word_t operand_a_i,
    input  exu_pkg::data_word_t operand_b_i,
    input  exu_pkg::csr_addr_t  csr_addr_i,

    // Host response
    output logic                ack_o,
    output exu_pkg::data_word_t result_o,
    output logic                exception_o,

    // Status register bit 3
    output logic                glb_interrupt_enable_o
);

    logic                busy;
    logic                bad_op_done;
    logic                retire;
    logic                itu_done;
    exu_pkg::data_word_t itu_data;
    logic                csr_done;
    exu_pkg::data_word_t csr_data;
    logic                csr_exception;

    exu_issue_if issue_bus ();

    //====================
    // Decode
    //====================

    uop_decoder uop_decoder_i (
        .clk_i         ( clk_i       ),
        .rst_n_i       ( rst_n_i     ),
        .req_i         ( req_i       ),
        .op_i          ( op_i        ),
        .operand_a_i   ( operand_a_i ),
        .operand_b_i   ( operand_b_i ),
        .csr_addr_i    ( csr_addr_i  ),
        .busy_i        ( busy        ),
        .issue         ( issue_bus   ),
        .bad_op_done_o ( bad_op_done )
    );

    //====================
    // Execute
    //====================

    integer_unit integer_unit_i (
        .clk_i   ( clk_i     ),
        .rst_n_i ( rst_n_i   ),
        .issue   ( issue_bus ),
        .done_o  ( itu_done  ),
        .data_o  ( itu_data  )
    );

    csr_unit csr_unit_i (
        .clk_i                  ( clk_i                  ),
        .rst_n_i                ( rst_n_i                ),
        .issue                  ( issue_bus              ),
        .retire_i               ( retire                 ),
        .done_o                 ( csr_done               ),
        .data_o                 ( csr_data               ),
        .exception_o            ( csr_exception          ),
        .glb_interrupt_enable_o ( glb_interrupt_enable_o )
    );

    //====================
    // Result
    //====================

    result_writeback result_writeback_i (
        .clk_i           ( clk_i         ),
        .rst_n_i         ( rst_n_i       ),
        .req_i           ( req_i         ),
        .itu_done_i      ( itu_done      ),
        .itu_data_i      ( itu_data      ),
        .csr_done_i      ( csr_done      ),
        .csr_data_i      ( csr_data      ),
        .csr_exception_i ( csr_exception ),
        .bad_op_done_i   ( bad_op_done   ),
        .busy_o          ( busy          ),
        .retire_o        ( retire        ),
        .ack_o           ( ack_o         ),
        .result_o        ( result_o      ),
        .exception_o     ( exception_o   )
    );

endmodule : execution_unit

// ==== execution_unit_sva.sv ====
//====================
// Execution unit assertions
// Handshake and issue bus rules checked at the top level
//====================

`timescale 1ns/100ps

module execution_unit_sva (
    input logic                clk_i,
    input logic                rst_n_i,
    input logic                req_i,
    input logic                ack_i,
    input exu_pkg::data_word_t result_i,
    input logic                exception_i,
    input logic                issue_valid_i
);

    // The DUT only answers a request that is still up
    ack_needs_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(ack_i) |-> req_i)
        else $error("ack_o rose while req_i was low");

    // Release takes exactly one cycle
    ack_release: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (ack_i && !req_i) |=> !ack_i)
        else $error("ack_o stayed high one cycle after req_i fell");

    // Response holds while ack is up
    response_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ack_i |=> (!ack_i || ($stable(result_i) && $stable(exception_i))))
        else $error("response changed while ack_o was high");

    // Issue strobe is a single cycle pulse
    issue_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        issue_valid_i |=> !issue_valid_i)
        else $error("issue valid held for more than one cycle");

endmodule : execution_unit_sva

bind execution_unit execution_unit_sva execution_unit_sva_i (
    .clk_i         ( clk_i           ),
    .rst_n_i       ( rst_n_i         ),
    .req_i         ( req_i           ),
    .ack_i         ( ack_o           ),
    .result_i      ( result_o        ),
    .exception_i   ( exception_o     ),
    .issue_valid_i ( issue_bus.valid )
);

// ==== exu_issue_if.sv ====
//====================
// Issue bus
// Carries one decoded operation from the decoder to the units
//====================

`timescale 1ns/100ps

interface exu_issue_if;

    // Single cycle strobe, the other fields are valid with it
    logic                  valid;

    // Unit the operation is addressed to
    exu_pkg::exu_unit_t    unit;
    exu_pkg::exu_op_t      op;

    // Operands and CSR address as registered by the decoder
    exu_pkg::data_word_t   operand_a;
    exu_pkg::data_word_t   operand_b;
    exu_pkg::csr_addr_t    csr_addr;

    // Decoder side
    modport source (
        output valid, unit, op, operand_a, operand_b, csr_addr
    );

    // Functional unit side
    modport sink (
        input valid, unit, op, operand_a, operand_b, csr_addr
    );

endinterface : exu_issue_if

// ==== exu_pkg.sv ====
//====================
// Execution unit package
// Shared widths, opcode and unit encodings, CSR map and the
// state encodings of the divider and result stage FSMs
//====================

package exu_pkg;

    //====================
    // Widths
    //====================

    localparam int DATA_WIDTH     = 32;
    localparam int CSR_ADDR_WIDTH = 12;

    // Number of restoring divider iterations, one per quotient bit
    localparam int DIV_STEPS = 32;

    typedef logic [DATA_WIDTH-1:0]        data_word_t;
    typedef logic [CSR_ADDR_WIDTH-1:0]    csr_addr_t;
    typedef logic [$clog2(DIV_STEPS)-1:0] div_count_t;

    //====================
    // Operation encodings
    //====================

    // Codes 14 and 15 are left undefined and are trapped by the decoder
    typedef enum logic [3:0] {
        OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SRL, OP_SLT,
        OP_MUL, OP_DIVU, OP_REMU, OP_CSRRW, OP_CSRRS, OP_CSRRC
    } exu_op_t;

    // Destination functional unit of a decoded operation
    typedef enum logic [1:0] {
        UNIT_ITU, UNIT_CSR, UNIT_NONE
    } exu_unit_t;

    //====================
    // CSR map
    //====================

    localparam csr_addr_t CSR_STATUS  = 12'h300;
    localparam csr_addr_t CSR_SCRATCH = 12'h340;
    localparam csr_addr_t CSR_INSTRET = 12'hC02;

    // Global interrupt enable is the only writable status bit
    localparam int         STATUS_GIE_BIT    = 3;
    localparam data_word_t STATUS_WRITE_MASK = 32'h0000_0008;

    //====================
    // State encodings
    //====================

    typedef enum logic [1:0] {
        DIV_IDLE, DIV_RUN, DIV_DONE
    } div_state_t;

    typedef enum logic [1:0] {
        WB_IDLE, WB_WAIT, WB_ACK
    } wb_state_t;

endpackage : exu_pkg

// ==== integer_unit.sv ====
//====================
// Integer unit
// Single cycle ALU and low multiply, plus an iterative
// restoring divider for unsigned quotient and remainder
//====================

`timescale 1ns/100ps

module integer_unit (
    input  logic                clk_i,
    input  logic                rst_n_i,
    exu_issue_if.sink           issue,
    output logic                done_o,
    output exu_pkg::data_word_t data_o
);

    logic                itu_hit;
    logic                is_div;
    exu_pkg::data_word_t alu_result;
    logic                alu_done_q;
    exu_pkg::data_word_t alu_data_q;

    assign itu_hit = issue.valid && (issue.unit == exu_pkg::UNIT_ITU);
    assign is_div  = (issue.op == exu_pkg::OP_DIVU) || (issue.op == exu_pkg::OP_REMU);

    //====================
    // Single cycle path
    //====================

    always_comb begin : alu_logic
        case (issue.op)
            exu_pkg::OP_ADD: alu_result = issue.operand_a + issue.operand_b;
            exu_pkg::OP_SUB: alu_result = issue.operand_a - issue.operand_b;
            exu_pkg::OP_AND: alu_result = issue.operand_a & issue.operand_b;
            exu_pkg::OP_OR:  alu_result = issue.operand_a | issue.operand_b;
            exu_pkg::OP_XOR: alu_result = issue.operand_a ^ issue.operand_b;
            exu_pkg::OP_SLL: alu_result = issue.operand_a << issue.operand_b[4:0];
            exu_pkg::OP_SRL: alu_result = issue.operand_a >> issue.operand_b[4:0];
            exu_pkg::OP_SLT: alu_result =
                ($signed(issue.operand_a) < $signed(issue.operand_b)) ? 32'd1 : 32'd0;
            // Only the low half of the product is kept
            exu_pkg::OP_MUL: alu_result = issue.operand_a * issue.operand_b;
            default:         alu_result = '0;
        endcase
    end : alu_logic

    always_ff @(posedge clk_i or negedge rst_n_i) begin : alu_done_reg
        if (!rst_n_i) begin
            alu_done_q <= 1'b0;
        end else begin
            alu_done_q <= itu_hit && !is_div;
        end
    end : alu_done_reg

    always_ff @(posedge clk_i) begin : alu_data_reg
        if (itu_hit && !is_div) begin
            alu_data_q <= alu_result;
        end
    end : alu_data_reg

    //====================
    // Divider
    //====================

    exu_pkg::div_state_t div_state;
    exu_pkg::div_count_t step_cnt_q;
    exu_pkg::data_word_t divisor_q;
    exu_pkg::data_word_t quotient_q;
    exu_pkg::data_word_t remainder_q;
    logic                rem_sel_q;
    logic [exu_pkg::DATA_WIDTH:0] shifted;
    logic [exu_pkg::DATA_WIDTH:0] diff;

    // Partial remainder shifted left with the next dividend bit brought in
    assign shifted = {remainder_q, quotient_q[exu_pkg::DATA_WIDTH-1]};
    assign diff    = shifted - {1'b0, divisor_q};

    always_ff @(posedge clk_i or negedge rst_n_i) begin : div_fsm
        if (!rst_n_i) begin
            div_state  <= exu_pkg::DIV_IDLE;
            step_cnt_q <= '0;
        end else begin
            case (div_state)
                exu_pkg::DIV_IDLE: if (itu_hit && is_div) begin
                    div_state  <= exu_pkg::DIV_RUN;
                    step_cnt_q <= '0;
                end

                exu_pkg::DIV_RUN: begin
                    step_cnt_q <= step_cnt_q + 1'b1;
                    if (step_cnt_q == exu_pkg::div_count_t'(exu_pkg::DIV_STEPS - 1)) begin
                        div_state <= exu_pkg::DIV_DONE;
                    end
                end

                default: div_state <= exu_pkg::DIV_IDLE;
            endcase
        end
    end : div_fsm

    // A zero divisor always subtracts, giving all ones and the dividend back
    always_ff @(posedge clk_i) begin : div_datapath
        if ((div_state == exu_pkg::DIV_IDLE) && itu_hit && is_div) begin
            divisor_q   <= issue.operand_b;
            quotient_q  <= issue.operand_a;
            remainder_q <= '0;
            rem_sel_q   <= (issue.op == exu_pkg::OP_REMU);
        end else if (div_state == exu_pkg::DIV_RUN) begin
            if (!diff[exu_pkg::DATA_WIDTH]) begin
                remainder_q <= diff[exu_pkg::DATA_WIDTH-1:0];
                quotient_q  <= {quotient_q[exu_pkg::DATA_WIDTH-2:0], 1'b1};
            end else begin
                remainder_q <= shifted[exu_pkg::DATA_WIDTH-1:0];
                quotient_q  <= {quotient_q[exu_pkg::DATA_WIDTH-2:0], 1'b0};
            end
        end
    end : div_datapath

    // DIV_DONE lasts one cycle, so the done pulse stays single
    assign done_o = alu_done_q || (div_state == exu_pkg::DIV_DONE);
    assign data_o = (div_state == exu_pkg::DIV_DONE) ?
                    (rem_sel_q ? remainder_q : quotient_q) : alu_data_q;

endmodule : integer_unit

// ==== result_writeback.sv ====
//====================
// Result stage
// Holds the unit result and runs the host side of the handshake
//====================

`timescale 1ns/100ps

module result_writeback (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                req_i,
    input  logic                itu_done_i,
    input  exu_pkg::data_word_t itu_data_i,
    input  logic                csr_done_i,
    input  exu_pkg::data_word_t csr_data_i,
    input  logic                csr_exception_i,
    input  logic                bad_op_done_i,
    output logic                busy_o,
    output logic                retire_o,
    output logic                ack_o,
    output exu_pkg::data_word_t result_o,
    output logic                exception_o
);

    exu_pkg::wb_state_t state;
    logic               any_done;

    assign any_done = itu_done_i || csr_done_i || bad_op_done_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin : wb_fsm
        if (!rst_n_i) begin
            state       <= exu_pkg::WB_IDLE;
            result_o    <= '0;
            exception_o <= 1'b0;
            retire_o    <= 1'b0;
        end else begin
            retire_o <= 1'b0;

            case (state)
                exu_pkg::WB_IDLE: if (req_i) begin
                    state <= exu_pkg::WB_WAIT;
                end

                // Only one unit pulses per operation
                exu_pkg::WB_WAIT: if (any_done) begin
                    state <= exu_pkg::WB_ACK;
                    if (itu_done_i) begin
                        result_o    <= itu_data_i;
                        exception_o <= 1'b0;
                        retire_o    <= 1'b1;
                    end else if (csr_done_i) begin
                        result_o    <= csr_data_i;
                        exception_o <= csr_exception_i;
                        retire_o    <= !csr_exception_i;
                    end else begin
                        // Undefined opcode
                        result_o    <= '0;
                        exception_o <= 1'b1;
                    end
                end

                // Result stays put until the host drops the request
                exu_pkg::WB_ACK: if (!req_i) begin
                    state <= exu_pkg::WB_IDLE;
                end

                default: state <= exu_pkg::WB_IDLE;
            endcase
        end
    end : wb_fsm

    assign ack_o  = (state == exu_pkg::WB_ACK);
    assign busy_o = (state != exu_pkg::WB_IDLE);

endmodule : result_writeback

// ==== tb_execution_unit.sv ====
//====================
// Execution unit testbench
// Runs operations over the req/ack handshake and checks each
// response against a reference model of the execution stage
//====================

`timescale 1ns/100ps

module tb_execution_unit;

    // Worst case per op is the divider plus handshake and release slack
    localparam int OP_BUDGET      = 300;
    localparam int CYCLES_PER_OP  = exu_pkg::DIV_STEPS + 2 + 8;
    localparam int TIMEOUT_CYCLES = OP_BUDGET * CYCLES_PER_OP + 500;

    logic                clk;
    logic                rst_n;
    logic                req;
    exu_pkg::exu_op_t    op;
    exu_pkg::data_word_t operand_a;
    exu_pkg::data_word_t operand_b;
    exu_pkg::csr_addr_t  csr_addr;
    logic                ack;
    exu_pkg::data_word_t result;
    logic                exception;
    logic                gie;

    integer seed;
    int     cycle_count = 0;
    int     latency;

    // Model copies of the CSRs
    exu_pkg::data_word_t model_status;
    exu_pkg::data_word_t model_scratch;
    exu_pkg::data_word_t model_instret;

    // Expected responses in issue order
    exu_pkg::data_word_t exp_data_q[$];
    logic                exp_exc_q[$];

    // Response seen at the last ack rise
    logic                ack_seen = 1'b0;
    exu_pkg::data_word_t held_data;
    logic                held_exc;

    execution_unit execution_unit_i (
        .clk_i                  ( clk       ),
        .rst_n_i                ( rst_n     ),
        .req_i                  ( req       ),
        .op_i                   ( op        ),
        .operand_a_i            ( operand_a ),
        .operand_b_i            ( operand_b ),
        .csr_addr_i             ( csr_addr  ),
        .ack_o                  ( ack       ),
        .result_o               ( result    ),
        .exception_o            ( exception ),
        .glb_interrupt_enable_o ( gie       )
    );

    initial begin : clock_gen
        clk = 1'b0;
        forever #50 clk = ~clk;
    end : clock_gen

    always @(posedge clk) begin : watchdog
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the DUT did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("test failed");
            $fatal(1, "simulation stopped by the cycle limit");
        end
    end : watchdog

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("ERROR at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
            $display("test failed");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    //====================
    // Reference model
    //====================

    // Computes the expected result and exception of one op and advances the CSR copies
    function automatic exu_pkg::data_word_t exu_model(
        input exu_pkg::exu_op_t    op_code,
        input exu_pkg::data_word_t a,
        input exu_pkg::data_word_t b,
        input exu_pkg::csr_addr_t  addr,
        output logic               exc
    );
        exu_pkg::data_word_t res;
        exu_pkg::data_word_t old;
        exu_pkg::data_word_t upd;
        logic                known;
        res   = '0;
        old   = '0;
        exc   = 1'b0;
        known = 1'b1;
        case (op_code)
            exu_pkg::OP_ADD:  res = a + b;
            exu_pkg::OP_SUB:  res = a - b;
            exu_pkg::OP_AND:  res = a & b;
            exu_pkg::OP_OR:   res = a | b;
            exu_pkg::OP_XOR:  res = a ^ b;
            exu_pkg::OP_SLL:  res = a << b[4:0];
            exu_pkg::OP_SRL:  res = a >> b[4:0];
            exu_pkg::OP_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            exu_pkg::OP_MUL:  res = a * b;
            // Division by zero gives all ones and leaves the dividend as remainder
            exu_pkg::OP_DIVU: res = (b == '0) ? '1 : a / b;
            exu_pkg::OP_REMU: res = (b == '0) ? a : a % b;
            exu_pkg::OP_CSRRW, exu_pkg::OP_CSRRS, exu_pkg::OP_CSRRC: begin
                case (addr)
                    exu_pkg::CSR_STATUS:  old = model_status;
                    exu_pkg::CSR_SCRATCH: old = model_scratch;
                    exu_pkg::CSR_INSTRET: old = model_instret;
                    default:              known = 1'b0;
                endcase
                if (op_code == exu_pkg::OP_CSRRW) begin
                    upd = a;
                end else if (op_code == exu_pkg::OP_CSRRS) begin
                    upd = old | a;
                end else begin
                    upd = old & ~a;
                end
                // The retired counter only allows a read with a zero mask
                exc = !known || ((addr == exu_pkg::CSR_INSTRET) &&
                                 ((op_code == exu_pkg::OP_CSRRW) || (a != '0)));
                if (!exc) begin
                    res = old;
                    if (addr == exu_pkg::CSR_STATUS) begin
                        model_status = upd & exu_pkg::STATUS_WRITE_MASK;
                    end
                    if (addr == exu_pkg::CSR_SCRATCH) begin
                        model_scratch = upd;
                    end
                end
            end
            default: exc = 1'b1;
        endcase
        if (!exc) begin
            model_instret = model_instret + 1;
        end
        return res;
    endfunction

    // Operand with a bias towards the edge values
    function automatic exu_pkg::data_word_t pick_operand();
        case ($unsigned($random(seed)) % 5)
            0:       return '0;
            1:       return '1;
            2:       return 32'd31;
            default: return $random(seed);
        endcase
    endfunction

    //====================
    // Host side
    //====================

    // Runs the full four phase handshake and counts the edges from the req drive to ack
    task automatic issue_op(input exu_pkg::exu_op_t op_code, input exu_pkg::data_word_t a,
                            input exu_pkg::data_word_t b, input exu_pkg::csr_addr_t addr,
                            input int hold_extra);
        exu_pkg::data_word_t exp_data;
        logic                exp_exc;
        int                  release_wait;
        exp_data = exu_model(op_code, a, b, addr, exp_exc);
        exp_data_q.push_back(exp_data);
        exp_exc_q.push_back(exp_exc);
        @(posedge clk);
        req       <= 1'b1;
        op        <= op_code;
        operand_a <= a;
        operand_b <= b;
        csr_addr  <= addr;
        latency = 0;
        do begin
            @(posedge clk);
            latency++;
            @(negedge clk);
        end while (!ack);
        check_value(32'(gie), 32'(model_status[exu_pkg::STATUS_GIE_BIT]),
                    "glb_interrupt_enable_o");
        release_wait = hold_extra + int'($unsigned($random(seed)) % 4);
        repeat (release_wait) @(posedge clk);
        @(posedge clk);
        req <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        check_value(32'(ack), 32'd0, "ack_o one cycle after req_i fell");
    endtask

    // Compares each response at its ack rise, then watches it while ack is high
    always @(negedge clk) begin : response_monitor
        if (rst_n && ack && !ack_seen) begin
            check_value(32'(exp_data_q.size()), 32'd1, "responses outstanding at ack_o");
            check_value(result, exp_data_q.pop_front(), "result_o");
            check_value(32'(exception), 32'(exp_exc_q.pop_front()), "exception_o");
            held_data = result;
            held_exc  = exception;
        end else if (ack && ack_seen) begin
            check_value(result, held_data, "result_o changed while ack_o high");
            check_value(32'(exception), 32'(held_exc), "exception_o changed while ack_o high");
        end else if (!ack && ack_seen && req) begin
            check_value(32'(ack), 32'd1, "ack_o fell while req_i was held");
        end
        ack_seen = ack;
    end : response_monitor

    //====================
    // Test sequence
    //====================

    initial begin : stimulus
        exu_pkg::data_word_t a;
        exu_pkg::data_word_t b;
        logic [3:0]          code;
        seed          = 32'h316e_0af8;
        model_status  = '0;
        model_scratch = '0;
        model_instret = '0;
        rst_n     = 1'b0;
        req       = 1'b0;
        op        = exu_pkg::OP_ADD;
        operand_a = '0;
        operand_b = '0;
        csr_addr  = '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value(32'(ack), 32'd0, "ack_o after reset");
        check_value(32'(exception), 32'd0, "exception_o after reset");
        check_value(32'(gie), 32'd0, "glb_interrupt_enable_o after reset");
        check_value(result, 32'd0, "result_o after reset");

        // One ADD with the fixed three cycle latency
        issue_op(exu_pkg::OP_ADD, 32'd1234, 32'd4321, '0, 0);
        check_value(32'(latency), 32'd3, "ADD latency in cycles");

        // ALU and multiply with edge operands mixed in
        repeat (200) begin
            code = 4'($unsigned($random(seed)) % 9);
            a = pick_operand();
            b = pick_operand();
            issue_op(exu_pkg::exu_op_t'(code), a, b, '0, 0);
        end

        // Divider with divisors of varied magnitude, then zero divisors
        repeat (20) begin
            code = ($random(seed) & 1) ? 4'(exu_pkg::OP_REMU) : 4'(exu_pkg::OP_DIVU);
            a = $random(seed);
            b = $random(seed);
            b = b >> ($unsigned($random(seed)) % 32);
            issue_op(exu_pkg::exu_op_t'(code), a, b, '0, 0);
        end
        issue_op(exu_pkg::OP_DIVU, 32'hDEAD_BEEF, '0, '0, 0);
        issue_op(exu_pkg::OP_REMU, 32'hDEAD_BEEF, '0, '0, 0);

        // Scratch swap, set and clear
        issue_op(exu_pkg::OP_CSRRW, 32'hA5A5_5A5A, '0, exu_pkg::CSR_SCRATCH, 0);
        issue_op(exu_pkg::OP_CSRRS, 32'h0000_00FF, '0, exu_pkg::CSR_SCRATCH, 0);
        issue_op(exu_pkg::OP_CSRRC, 32'hA000_000F, '0, exu_pkg::CSR_SCRATCH, 0);
        issue_op(exu_pkg::OP_CSRRS, '0, '0, exu_pkg::CSR_SCRATCH, 0);

        // Status keeps only the interrupt enable bit
        issue_op(exu_pkg::OP_CSRRW, 32'hFFFF_FFFF, '0, exu_pkg::CSR_STATUS, 0);
        issue_op(exu_pkg::OP_CSRRS, '0, '0, exu_pkg::CSR_STATUS, 0);
        issue_op(exu_pkg::OP_CSRRC, 32'h0000_0008, '0, exu_pkg::CSR_STATUS, 0);
        issue_op(exu_pkg::OP_CSRRS, 32'h0000_0008, '0, exu_pkg::CSR_STATUS, 0);
        issue_op(exu_pkg::OP_CSRRC, 32'hFFFF_FFFF, '0, exu_pkg::CSR_STATUS, 0);
        issue_op(exu_pkg::OP_CSRRS, 32'h0000_0008, '0, exu_pkg::CSR_STATUS, 0);

        // Illegal accesses and undefined codes
        issue_op(exu_pkg::OP_CSRRW, 32'h1234_5678, '0, 12'h7C0, 0);
        issue_op(exu_pkg::OP_CSRRS, '0, '0, 12'h001, 0);
        issue_op(exu_pkg::OP_CSRRW, 32'd5, '0, exu_pkg::CSR_INSTRET, 0);
        issue_op(exu_pkg::OP_CSRRS, 32'd1, '0, exu_pkg::CSR_INSTRET, 0);
        issue_op(exu_pkg::OP_CSRRC, 32'h0000_FFFF, '0, exu_pkg::CSR_INSTRET, 0);
        issue_op(exu_pkg::exu_op_t'(4'd14), 32'd7, 32'd9, '0, 0);
        check_value(32'(latency), 32'd2, "undefined opcode latency in cycles");
        issue_op(exu_pkg::exu_op_t'(4'd15), 32'd7, 32'd9, '0, 0);

        // State after the illegal accesses, and the retired count
        issue_op(exu_pkg::OP_CSRRS, '0, '0, exu_pkg::CSR_SCRATCH, 0);
        issue_op(exu_pkg::OP_CSRRS, '0, '0, exu_pkg::CSR_STATUS, 0);
        issue_op(exu_pkg::OP_CSRRS, '0, '0, exu_pkg::CSR_INSTRET, 0);

        // Host keeps req_i up for a few extra cycles
        repeat (20) begin
            code = 4'($unsigned($random(seed)) % 11);
            a = pick_operand();
            b = pick_operand();
            issue_op(exu_pkg::exu_op_t'(code), a, b, '0, 1 + int'($unsigned($random(seed)) % 4));
        end

        $display("test passed");
        $finish;
    end : stimulus

endmodule : tb_execution_unit

// ==== uop_decoder.sv ====
//====================
// Micro-operation decoder
// Accepts a new request, picks the target unit and issues it
//====================

`timescale 1ns/100ps

module uop_decoder (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                req_i,
    input  exu_pkg::exu_op_t    op_i,
    input  exu_pkg::data_word_t operand_a_i,
    input  exu_pkg::data_word_t operand_b_i,
    input  exu_pkg::csr_addr_t  csr_addr_i,
    input  logic                busy_i,
    exu_issue_if.source         issue,
    output logic                bad_op_done_o
);

    exu_pkg::exu_unit_t unit_sel;
    logic               new_req;
    logic               valid_q;
    logic               bad_op_q;

    // Registered copy of the request that goes out on the issue bus
    exu_pkg::exu_unit_t  unit_q;
    exu_pkg::exu_op_t    op_q;
    exu_pkg::data_word_t operand_a_q;
    exu_pkg::data_word_t operand_b_q;
    exu_pkg::csr_addr_t  csr_addr_q;

    // A request counts only once the result stage is idle and the last issue has left
    assign new_req = req_i && !busy_i && !valid_q && !bad_op_q;

    // Opcode classification
    always_comb begin : unit_select
        case (op_i)
            exu_pkg::OP_ADD, exu_pkg::OP_SUB, exu_pkg::OP_AND, exu_pkg::OP_OR,
            exu_pkg::OP_XOR, exu_pkg::OP_SLL, exu_pkg::OP_SRL, exu_pkg::OP_SLT,
            exu_pkg::OP_MUL, exu_pkg::OP_DIVU, exu_pkg::OP_REMU:
                unit_sel = exu_pkg::UNIT_ITU;

            exu_pkg::OP_CSRRW, exu_pkg::OP_CSRRS, exu_pkg::OP_CSRRC:
                unit_sel = exu_pkg::UNIT_CSR;

            // Codes past CSRRC have no owner
            default: unit_sel = exu_pkg::UNIT_NONE;
        endcase
    end : unit_select

    // Strobes, both pulse for one cycle
    always_ff @(posedge clk_i or negedge rst_n_i) begin : strobe_reg
        if (!rst_n_i) begin
            valid_q  <= 1'b0;
            bad_op_q <= 1'b0;
        end else begin
            valid_q  <= new_req && (unit_sel != exu_pkg::UNIT_NONE);
            bad_op_q <= new_req && (unit_sel == exu_pkg::UNIT_NONE);
        end
    end : strobe_reg

    // Payload is only loaded on an accepted request
    always_ff @(posedge clk_i) begin : payload_reg
        if (new_req) begin
            unit_q      <= unit_sel;
            op_q        <= op_i;
            operand_a_q <= operand_a_i;
            operand_b_q <= operand_b_i;
            csr_addr_q  <= csr_addr_i;
        end
    end : payload_reg

    assign issue.valid     = valid_q;
    assign issue.unit      = unit_q;
    assign issue.op        = op_q;
    assign issue.operand_a = operand_a_q;
    assign issue.operand_b = operand_b_q;
    assign issue.csr_addr  = csr_addr_q;

    // An undefined opcode completes right here, in step with the issue
    assign bad_op_done_o = bad_op_q;

endmodule : uop_decoder
